//--- flist.f
+incdir+source
source/rv_pkg.sv
source/decode_if.sv
source/decoder.sv
source/regfile.sv
source/decode_control.sv
source/decode_stage.sv
test/tb_decode_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks for the pass line

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    -f flist.f --top-module tb_decode_stage -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_output=$(./obj_dir/Vtb_decode_stage 2>&1); then
  echo "$sim_output"
  echo "Simulation exited with an error status"
  exit 1
fi

echo "$sim_output"

if grep -qx "TESTBENCH PASSED" <<< "$sim_output"; then
  exit 0
else
  exit 1
fi

//--- source/decode_control.sv
// Opcode control decode, immediate select and the decode-to-execute register with stall
`timescale 1ns/1ps
`include "rv_settings.svh"

module decode_control #(
  parameter int XLEN = `XLEN
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               instr_valid,
  input  logic               stall,
  decode_if.ctl              ctl,
  input  logic [XLEN-1:0]    rs1_data,
  input  logic [XLEN-1:0]    rs2_data,
  output logic               out_valid,
  output logic [`REG_AW-1:0] out_rd,
  output logic [XLEN-1:0]    out_rs1_data,
  output logic [XLEN-1:0]    out_rs2_data,
  output logic [XLEN-1:0]    out_imm,
  output rv_pkg::alu_op_e    out_alu_op,
  output logic               out_alu_src_imm,
  output logic               out_reg_write,
  output logic               out_mem_read,
  output logic               out_mem_write,
  output logic               out_branch,
  output logic               out_jump,
  output logic [11:0]        out_csr_addr,
  output logic [4:0]         out_csr_uimm,
  output logic               out_is_csr,
  output logic               out_is_ecall,
  output logic               out_is_ebreak,
  output logic               out_is_mret,
  output logic               out_illegal
);
  import rv_pkg::*;

  imm_sel_e        imm_sel;
  alu_op_e         alu_op;
  logic            alu_src_imm;
  logic            reg_write;
  logic            mem_read;
  logic            mem_write;
  logic            branch;
  logic            jump;
  logic            illegal;
  logic [XLEN-1:0] imm;
  // Load enable of the pipeline register
  logic            load;

  // funct3 picks the op, funct7[5] splits ADD/SUB and SRL/SRA
  // SUB only exists in the register form
  function automatic alu_op_e alu_from_funct(input logic [2:0] funct3,
                                             input logic       f7b5,
                                             input logic       is_reg);
    alu_op_e op;
    case (funct3)
      3'b000: begin
        if (is_reg && f7b5) op = ALU_SUB;
        else                op = ALU_ADD;
      end
      3'b001: op = ALU_SLL;
      3'b010: op = ALU_SLT;
      3'b011: op = ALU_SLTU;
      3'b100: op = ALU_XOR;
      3'b101: begin
        if (f7b5) op = ALU_SRA;
        else      op = ALU_SRL;
      end
      3'b110: op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // ====================
  // Opcode decode
  // ====================

  always_comb begin
    imm_sel     = IMM_NONE;
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    reg_write   = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    illegal     = 1'b0;
    case (ctl.opcode)
      OPC_LOAD: begin
        // Address = rs1 + imm
        imm_sel     = IMM_I;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        mem_read    = 1'b1;
      end
      OPC_STORE: begin
        imm_sel     = IMM_S;
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      OPC_OP, OPC_OP_32: begin
        alu_op    = alu_from_funct(ctl.funct3, ctl.funct7[5], 1'b1);
        reg_write = 1'b1;
        // Word ops only on RV64
        illegal   = (ctl.opcode == OPC_OP_32) && (XLEN == 32);
      end
      OPC_OP_IMM, OPC_OP_IMM_32: begin
        // SRAI carries its funct7[5] in the immediate
        imm_sel     = IMM_I;
        alu_op      = alu_from_funct(ctl.funct3, ctl.funct7[5], 1'b0);
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        illegal     = (ctl.opcode == OPC_OP_IMM_32) && (XLEN == 32);
      end
      OPC_BRANCH: begin
        // Compare by subtraction, target add done in execute
        imm_sel = IMM_B;
        alu_op  = ALU_SUB;
        branch  = 1'b1;
      end
      OPC_JAL: begin
        imm_sel     = IMM_J;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        jump        = 1'b1;
      end
      OPC_JALR: begin
        imm_sel     = IMM_I;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        jump        = 1'b1;
      end
      OPC_LUI: begin
        imm_sel     = IMM_U;
        alu_op      = ALU_PASS_B;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
      end
      OPC_AUIPC: begin
        imm_sel     = IMM_U;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
      end
      OPC_SYSTEM: begin
        // Only CSR ops write rd, old CSR value
        reg_write = ctl.is_csr;
      end
      default: illegal = 1'b1;
    endcase
    // Nothing architectural for a bad opcode
    if (illegal) begin
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
    end
  end

  // Immediate mux
  always_comb begin
    case (imm_sel)
      IMM_I:   imm = ctl.imm_i;
      IMM_S:   imm = ctl.imm_s;
      IMM_B:   imm = ctl.imm_b;
      IMM_U:   imm = ctl.imm_u;
      IMM_J:   imm = ctl.imm_j;
      default: imm = '0;
    endcase
  end

  // ====================
  // Decode-to-execute register
  // ====================

  assign load = !stall;

  // Control levels, qualified by instr_valid so bubbles do nothing
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid       <= 1'b0;
      out_alu_op      <= ALU_ADD;
      out_alu_src_imm <= 1'b0;
      out_reg_write   <= 1'b0;
      out_mem_read    <= 1'b0;
      out_mem_write   <= 1'b0;
      out_branch      <= 1'b0;
      out_jump        <= 1'b0;
      out_is_csr      <= 1'b0;
      out_is_ecall    <= 1'b0;
      out_is_ebreak   <= 1'b0;
      out_is_mret     <= 1'b0;
      out_illegal     <= 1'b0;
    end else if (load) begin
      out_valid       <= instr_valid;
      out_alu_op      <= alu_op;
      out_alu_src_imm <= instr_valid && alu_src_imm;
      out_reg_write   <= instr_valid && reg_write;
      out_mem_read    <= instr_valid && mem_read;
      out_mem_write   <= instr_valid && mem_write;
      out_branch      <= instr_valid && branch;
      out_jump        <= instr_valid && jump;
      out_is_csr      <= instr_valid && ctl.is_csr;
      out_is_ecall    <= instr_valid && ctl.is_ecall;
      out_is_ebreak   <= instr_valid && ctl.is_ebreak;
      out_is_mret     <= instr_valid && ctl.is_mret;
      out_illegal     <= instr_valid && illegal;
    end
  end

  // Payload, held with the controls on stall
  always_ff @(posedge clk) begin
    if (load) begin
      out_rd       <= ctl.rd;
      out_rs1_data <= rs1_data;
      out_rs2_data <= rs2_data;
      out_imm      <= imm;
      out_csr_addr <= ctl.csr_addr;
      out_csr_uimm <= ctl.csr_uimm;
    end
  end

  // Illegal ops must never reach write-back
  assert property (@(posedge clk) disable iff (!rst_n) !(out_illegal && out_reg_write))
    else $error("decode_control: illegal instruction with reg_write");

  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid))
    else $error("decode_control: out_valid unknown after reset");

endmodule

//--- source/decode_if.sv
// Decoded fields, immediates and system flags between decoder, register file and control
`timescale 1ns/1ps
`include "rv_settings.svh"

interface decode_if #(
  parameter int XLEN = `XLEN
);

  // Raw fields, opcode kept as bits so unknown values survive
  logic [6:0]        opcode;
  logic [`REG_AW-1:0] rd;
  logic [`REG_AW-1:0] rs1;
  logic [`REG_AW-1:0] rs2;
  logic [2:0]        funct3;
  logic [6:0]        funct7;

  // Sign-extended immediates, one per format
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  // SYSTEM opcode details
  logic [11:0] csr_addr;
  logic [4:0]  csr_uimm;
  logic        is_csr;
  logic        is_ecall;
  logic        is_ebreak;
  logic        is_mret;

  // Decoder side
  modport dec (
    output opcode, rd, rs1, rs2, funct3, funct7,
    output imm_i, imm_s, imm_b, imm_u, imm_j,
    output csr_addr, csr_uimm, is_csr, is_ecall, is_ebreak, is_mret
  );

  // Control and pipeline register side
  modport ctl (
    input opcode, rd, rs1, rs2, funct3, funct7,
    input imm_i, imm_s, imm_b, imm_u, imm_j,
    input csr_addr, csr_uimm, is_csr, is_ecall, is_ebreak, is_mret
  );

  // Register file only needs the source addresses
  modport rf (
    input rs1, rs2
  );

endinterface

//--- source/decode_stage.sv
// Decode stage top level joining decoder, register file and control register
`timescale 1ns/1ps
`include "rv_settings.svh"

module decode_stage #(
  parameter int XLEN = `XLEN
) (
  input  logic               clk,
  input  logic               rst_n,
  // Fetch side
  input  logic [31:0]        instr,
  input  logic               instr_valid,
  input  logic               stall,
  // Write-back port
  input  logic               wb_en,
  input  logic [`REG_AW-1:0] wb_addr,
  input  logic [XLEN-1:0]    wb_data,
  // To execute
  output logic               out_valid,
  output logic [`REG_AW-1:0] out_rd,
  output logic [XLEN-1:0]    out_rs1_data,
  output logic [XLEN-1:0]    out_rs2_data,
  output logic [XLEN-1:0]    out_imm,
  output rv_pkg::alu_op_e    out_alu_op,
  output logic               out_alu_src_imm,
  output logic               out_reg_write,
  output logic               out_mem_read,
  output logic               out_mem_write,
  output logic               out_branch,
  output logic               out_jump,
  output logic [11:0]        out_csr_addr,
  output logic [4:0]         out_csr_uimm,
  output logic               out_is_csr,
  output logic               out_is_ecall,
  output logic               out_is_ebreak,
  output logic               out_is_mret,
  output logic               out_illegal
);
  import rv_pkg::*;

  // Raw word seen through the format union
  instr_t instr_word;

  // Operands from the register file
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;

  decode_if #(.XLEN(XLEN)) dif ();

  assign instr_word = instr;

  // ====================
  // Sub-blocks
  // ====================

  // Combinational field and immediate decode
  decoder #(.XLEN(XLEN)) u_decoder (
    .instr (instr_word),
    .dec   (dif.dec)
  );

  // Operand read with write-back forwarding
  regfile #(.XLEN(XLEN)) u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rf       (dif.rf),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

  // Control decode and the one pipeline register
  decode_control #(.XLEN(XLEN)) u_decode_control (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_valid     (instr_valid),
    .stall           (stall),
    .ctl             (dif.ctl),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .out_valid       (out_valid),
    .out_rd          (out_rd),
    .out_rs1_data    (out_rs1_data),
    .out_rs2_data    (out_rs2_data),
    .out_imm         (out_imm),
    .out_alu_op      (out_alu_op),
    .out_alu_src_imm (out_alu_src_imm),
    .out_reg_write   (out_reg_write),
    .out_mem_read    (out_mem_read),
    .out_mem_write   (out_mem_write),
    .out_branch      (out_branch),
    .out_jump        (out_jump),
    .out_csr_addr    (out_csr_addr),
    .out_csr_uimm    (out_csr_uimm),
    .out_is_csr      (out_is_csr),
    .out_is_ecall    (out_is_ecall),
    .out_is_ebreak   (out_is_ebreak),
    .out_is_mret     (out_is_mret),
    .out_illegal     (out_illegal)
  );

endmodule

//--- source/decoder.sv
// Instruction field extraction, immediate generation and SYSTEM instruction detection
`timescale 1ns/1ps
`include "rv_settings.svh"

module decoder #(
  parameter int XLEN = `XLEN
) (
  input rv_pkg::instr_t instr,
  decode_if.dec         dec
);
  import rv_pkg::*;

  // Raw immediates before widening, signed so the cast extends
  logic signed [11:0] raw_i;
  logic signed [11:0] raw_s;
  logic signed [12:0] raw_b;
  logic signed [31:0] raw_u;
  logic signed [20:0] raw_j;

  logic is_system;
  logic funct3_zero;

  // ====================
  // Field extraction
  // ====================

  // Register and function fields sit at fixed places in every format
  assign dec.opcode = instr.r_fmt.opcode;
  assign dec.rd     = instr.r_fmt.rd;
  assign dec.rs1    = instr.r_fmt.rs1;
  assign dec.rs2    = instr.r_fmt.rs2;
  assign dec.funct3 = instr.r_fmt.funct3;
  assign dec.funct7 = instr.r_fmt.funct7;

  // ====================
  // Immediates
  // ====================

  // I: word bits 31:20
  assign raw_i = instr.i_fmt.imm;

  // S: upper 7 bits and the rd slot
  assign raw_s = {instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};

  // B: halfword offset, bit 0 always zero
  assign raw_b = {instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                  instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};

  // U: upper 20 bits, low 12 cleared
  assign raw_u = {instr.u_fmt.imm_31_12, 12'h000};

  // J: reassemble the 20-bit offset, bit 0 zero
  assign raw_j = {instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                  instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

  // Widen to XLEN with sign extension
  // U keeps bit 31 as sign on RV64
  assign dec.imm_i = XLEN'(raw_i);
  assign dec.imm_s = XLEN'(raw_s);
  assign dec.imm_b = XLEN'(raw_b);
  assign dec.imm_u = XLEN'(raw_u);
  assign dec.imm_j = XLEN'(raw_j);

  // ====================
  // SYSTEM decode
  // ====================

  assign is_system   = (instr.i_fmt.opcode == OPC_SYSTEM);
  assign funct3_zero = (instr.i_fmt.funct3 == 3'b000);

  // CSR number lives in the I immediate slot
  assign dec.csr_addr = instr.i_fmt.imm;
  // zimm reuses the rs1 slot for the immediate CSR forms
  assign dec.csr_uimm = instr.i_fmt.rs1;

  // Any nonzero funct3 is one of the six CSR ops
  assign dec.is_csr = is_system && !funct3_zero;

  // funct3 zero, told apart by funct12
  assign dec.is_ecall  = is_system && funct3_zero && (instr.i_fmt.imm == 12'h000);
  assign dec.is_ebreak = is_system && funct3_zero && (instr.i_fmt.imm == 12'h001);
  // 0011000_00010
  assign dec.is_mret   = is_system && funct3_zero && (instr.i_fmt.imm == 12'h302);

  // Trap logic downstream relies on a single system flag
  always_comb begin
    assert final ($onehot0({dec.is_csr, dec.is_ecall, dec.is_ebreak, dec.is_mret}))
      else $error("decoder: more than one system flag set");
  end

endmodule

//--- source/regfile.sv
// Integer register file, two combinational reads, one write, x0 tied to zero
`timescale 1ns/1ps
`include "rv_settings.svh"

module regfile #(
  parameter int XLEN = `XLEN
) (
  input  logic               clk,
  input  logic               rst_n,
  decode_if.rf               rf,
  output logic [XLEN-1:0]    rs1_data,
  output logic [XLEN-1:0]    rs2_data,
  input  logic               wb_en,
  input  logic [`REG_AW-1:0] wb_addr,
  input  logic [XLEN-1:0]    wb_data
);

  logic [XLEN-1:0] regs [`NUM_REGS];

  // Write-back that actually lands in the array
  logic wb_live;
  logic fwd_rs1;
  logic fwd_rs2;

  assign wb_live = wb_en && (wb_addr != '0);

  // ====================
  // Write port
  // ====================

  // x0 never written, so it stays at its reset value
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_live) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // ====================
  // Read ports
  // ====================

  // Same-cycle write wins over the stored value
  assign fwd_rs1 = wb_live && (wb_addr == rf.rs1);
  assign fwd_rs2 = wb_live && (wb_addr == rf.rs2);

  // x0 decoded explicitly
  assign rs1_data = (rf.rs1 == '0) ? '0 :
                    fwd_rs1        ? wb_data : regs[rf.rs1];
  assign rs2_data = (rf.rs2 == '0) ? '0 :
                    fwd_rs2        ? wb_data : regs[rf.rs2];

  // x0 reads as zero on both ports, also during write-back
  assert property (@(posedge clk) disable iff (!rst_n)
    ((rf.rs1 == '0) |-> (rs1_data == '0)) and ((rf.rs2 == '0) |-> (rs2_data == '0)))
    else $error("regfile: x0 read returned nonzero");

endmodule

//--- source/rv_pkg.sv
// Instruction format union, opcode, immediate-select and ALU-operation enums
package rv_pkg;

  // ====================
  // Instruction formats
  // ====================

  // Register-register
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Register-immediate, loads, JALR, SYSTEM
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Stores, immediate split around rs fields
  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // Branches, bit 11 parked at word bit 7
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  // LUI and AUIPC
  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // JAL, scrambled 20-bit offset
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One 32-bit word, six views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_t;

  // ====================
  // Encodings
  // ====================

  // Base opcodes, RV32I plus the RV64I word ops
  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_32     = 7'b0111011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_SYSTEM    = 7'b1110011
  } opcode_e;

  // Which immediate the execute stage sees
  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J,
    IMM_NONE
  } imm_sel_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // Operand B straight through, for LUI
    ALU_PASS_B
  } alu_op_e;

endpackage

//--- source/rv_settings.svh
// Core width, register count and register-address width defines
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// ====================
// Datapath width
// ====================

// 32 for RV32I, 64 for RV64I
`define XLEN 32

// ====================
// Register file shape
// ====================

// Integer registers x0..x31
`define NUM_REGS 32
// Enough bits to index NUM_REGS
`define REG_AW 5

`endif

//--- test/decode_stimulus.txt
// instr valid stall wb_en wb_addr wb_data chk(0 none,1 all,2 valid+flags) exp_valid exp_rd
// exp_rs1 exp_rs2 exp_imm alu_op flags(src_imm rw mr mw br jmp csr ecall ebreak mret ill) csr uimm
002081B3 1 0 0 00 00000000 1 1 03 00000000 00000000 00000000 0 200 002 01
00000000 0 0 1 01 11111111 2 0 00 00000000 00000000 00000000 0 000 000 00
00000000 0 0 1 02 22222222 2 0 00 00000000 00000000 00000000 0 000 000 00
00000000 0 0 1 00 DEADBEEF 2 0 00 00000000 00000000 00000000 0 000 000 00
002081B3 1 0 0 00 00000000 1 1 03 11111111 22222222 00000000 0 200 002 01
40100233 1 0 0 00 00000000 1 1 04 00000000 11111111 00000000 1 200 401 00
007302B3 1 0 1 06 66666666 1 1 05 66666666 00000000 00000000 0 200 007 06
00134433 1 0 0 00 00000000 1 1 08 66666666 11111111 00000000 5 200 001 06
001154B3 1 0 0 00 00000000 1 1 09 22222222 11111111 00000000 6 200 001 02
401154B3 1 0 0 00 00000000 1 1 09 22222222 11111111 00000000 7 200 401 02
0020E533 1 0 0 00 00000000 1 1 0A 11111111 22222222 00000000 8 200 002 01
0020F5B3 1 0 0 00 00000000 1 1 0B 11111111 22222222 00000000 9 200 002 01
FFB10093 1 0 0 00 00000000 1 1 01 22222222 00000000 FFFFFFFB 0 600 FFB 02
4030D613 1 0 0 00 00000000 1 1 0C 11111111 00000000 00000403 7 600 403 01
00C12703 1 0 0 00 00000000 1 1 0E 22222222 00000000 0000000C 0 700 00C 02
FE20AC23 1 0 0 00 00000000 1 1 18 11111111 22222222 FFFFFFF8 0 480 FE2 01
FE2088E3 1 0 0 00 00000000 1 1 11 11111111 22222222 FFFFFFF0 1 040 FE2 01
ABCDE6B7 1 0 0 00 00000000 1 1 0D 00000000 00000000 ABCDE000 A 600 ABC 1B
FEDFF0EF 1 0 0 00 00000000 1 1 01 00000000 00000000 FFFFFFEC 0 620 FED 1F
305092F3 1 0 0 00 00000000 1 1 05 11111111 00000000 00000000 0 210 305 01
300D6073 1 0 0 00 00000000 1 1 00 00000000 00000000 00000000 0 210 300 1A
00000073 1 0 0 00 00000000 1 1 00 00000000 00000000 00000000 0 008 000 00
00100073 1 0 0 00 00000000 1 1 00 00000000 11111111 00000000 0 004 001 00
30200073 1 0 0 00 00000000 1 1 00 00000000 22222222 00000000 0 002 302 00
002081FF 1 0 0 00 00000000 1 1 03 11111111 22222222 00000000 0 001 002 01
0020E533 1 0 0 00 00000000 1 1 0A 11111111 22222222 00000000 8 200 002 01
0020F5B3 1 1 0 00 00000000 1 1 0A 11111111 22222222 00000000 8 200 002 01
0020F5B3 1 1 0 00 00000000 1 1 0A 11111111 22222222 00000000 8 200 002 01
0020F5B3 1 0 0 00 00000000 1 1 0B 11111111 22222222 00000000 9 200 002 01
00000000 0 0 0 00 00000000 2 0 00 00000000 00000000 00000000 0 000 000 00

//--- test/tb_decode_stage.sv
// Decode stage testbench with stimulus file replay and execute-side output checks
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_decode_stage;

  localparam int XLEN       = `XLEN;
  // Step and cycle limits of the run
  localparam int MAX_STEPS  = 200;
  localparam int MAX_CYCLES = 1000;

  // ====================
  // DUT signals
  // ====================

  logic               clk;
  logic               rst_n;
  logic [31:0]        instr;
  logic               instr_valid;
  logic               stall;
  logic               wb_en;
  logic [`REG_AW-1:0] wb_addr;
  logic [XLEN-1:0]    wb_data;
  logic               out_valid;
  logic [`REG_AW-1:0] out_rd;
  logic [XLEN-1:0]    out_rs1_data;
  logic [XLEN-1:0]    out_rs2_data;
  logic [XLEN-1:0]    out_imm;
  rv_pkg::alu_op_e    out_alu_op;
  logic               out_alu_src_imm;
  logic               out_reg_write;
  logic               out_mem_read;
  logic               out_mem_write;
  logic               out_branch;
  logic               out_jump;
  logic [11:0]        out_csr_addr;
  logic [4:0]         out_csr_uimm;
  logic               out_is_csr;
  logic               out_is_ecall;
  logic               out_is_ebreak;
  logic               out_is_mret;
  logic               out_illegal;

  // One stimulus line with the drive part then the expected part
  logic [63:0] f_instr, f_valid, f_stall, f_wb_en, f_wb_addr, f_wb_data;
  logic [63:0] f_chk, f_exp_valid, f_exp_rd, f_exp_rs1, f_exp_rs2, f_exp_imm;
  logic [63:0] f_exp_op, f_exp_flags, f_exp_csr, f_exp_uimm;

  int fd;
  int errors;
  int checks;

  // Flag column bits from the MSB down
  string flag_names [11] = '{"out_alu_src_imm", "out_reg_write", "out_mem_read",
                             "out_mem_write", "out_branch", "out_jump", "out_is_csr",
                             "out_is_ecall", "out_is_ebreak", "out_is_mret", "out_illegal"};

  decode_stage #(.XLEN(XLEN)) u_decode_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr           (instr),
    .instr_valid     (instr_valid),
    .stall           (stall),
    .wb_en           (wb_en),
    .wb_addr         (wb_addr),
    .wb_data         (wb_data),
    .out_valid       (out_valid),
    .out_rd          (out_rd),
    .out_rs1_data    (out_rs1_data),
    .out_rs2_data    (out_rs2_data),
    .out_imm         (out_imm),
    .out_alu_op      (out_alu_op),
    .out_alu_src_imm (out_alu_src_imm),
    .out_reg_write   (out_reg_write),
    .out_mem_read    (out_mem_read),
    .out_mem_write   (out_mem_write),
    .out_branch      (out_branch),
    .out_jump        (out_jump),
    .out_csr_addr    (out_csr_addr),
    .out_csr_uimm    (out_csr_uimm),
    .out_is_csr      (out_is_csr),
    .out_is_ecall    (out_is_ecall),
    .out_is_ebreak   (out_is_ebreak),
    .out_is_mret     (out_is_mret),
    .out_illegal     (out_illegal)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ====================
  // Helpers
  // ====================

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flags(input logic [10:0] exp);
    logic [10:0] got;
    got = {out_alu_src_imm, out_reg_write, out_mem_read, out_mem_write, out_branch,
           out_jump, out_is_csr, out_is_ecall, out_is_ebreak, out_is_mret, out_illegal};
    for (int i = 0; i < 11; i++) begin
      check_value(flag_names[i], 64'(got[10-i]), 64'(exp[10-i]));
    end
  endtask

  // Mode 1 checks everything and mode 2 only valid and flags
  task automatic check_step();
    if (f_chk != 64'd0) begin
      check_value("out_valid", 64'(out_valid), f_exp_valid);
      check_flags(f_exp_flags[10:0]);
    end
    if (f_chk == 64'd1) begin
      check_value("out_rd", 64'(out_rd), f_exp_rd);
      check_value("out_rs1_data", 64'(out_rs1_data), f_exp_rs1);
      check_value("out_rs2_data", 64'(out_rs2_data), f_exp_rs2);
      check_value("out_imm", 64'(out_imm), f_exp_imm);
      check_value("out_alu_op", 64'(out_alu_op), f_exp_op);
      check_value("out_csr_addr", 64'(out_csr_addr), f_exp_csr);
      check_value("out_csr_uimm", 64'(out_csr_uimm), f_exp_uimm);
    end
  endtask

  // Reads the next data line and skips comment and blank lines
  task automatic read_step(output bit ok);
    string line;
    int    n;
    int    code;
    ok = 1'b0;
    while (!ok && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_instr, f_valid, f_stall, f_wb_en, f_wb_addr, f_wb_data,
                    f_chk, f_exp_valid, f_exp_rd, f_exp_rs1, f_exp_rs2, f_exp_imm,
                    f_exp_op, f_exp_flags, f_exp_csr, f_exp_uimm);
        if (n == 16) begin
          ok = 1'b1;
        end else if (n > 0) begin
          errors++;
          $display("Malformed stimulus line, only %0d columns: %s", n, line);
        end
      end
    end
  endtask

  // ====================
  // Watchdog
  // ====================

  initial begin
    for (int cyc = 0; cyc < MAX_CYCLES; cyc++) begin
      @(posedge clk);
    end
    $display("Simulation did not finish within %0d clock cycles", MAX_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ====================
  // Main sequence
  // ====================

  initial begin
    bit ok;
    int steps;
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    stall       = 1'b0;
    wb_en       = 1'b0;
    wb_addr     = '0;
    wb_data     = '0;
    errors      = 0;
    checks      = 0;
    steps       = 0;
    f_chk       = '0;
    fd = $fopen("test/decode_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file test/decode_stimulus.txt");
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      repeat (16) @(posedge clk);
      // Controls cleared by reset
      #1;
      check_value("out_valid", 64'(out_valid), 64'd0);
      check_flags(11'h000);
      #1;
      rst_n = 1'b1;
      read_step(ok);
      while (ok && steps < MAX_STEPS) begin
        instr       = f_instr[31:0];
        instr_valid = f_valid[0];
        stall       = f_stall[0];
        wb_en       = f_wb_en[0];
        wb_addr     = f_wb_addr[`REG_AW-1:0];
        wb_data     = f_wb_data[XLEN-1:0];
        steps++;
        // Result of this step one edge later and sampled mid-cycle
        @(posedge clk);
        #1;
        check_step();
        #1;
        read_step(ok);
      end
      $fclose(fd);
      if (ok) begin
        errors++;
        $display("Stimulus file holds more than %0d steps", MAX_STEPS);
      end
      if (steps == 0) begin
        errors++;
        $display("Stimulus file holds no test steps");
      end
      $display("Steps: %0d, checks: %0d, errors: %0d", steps, checks, errors);
      if (errors == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

endmodule
